// File: rtl/nnTypesPkg.sv
package nnTypesPkg;

	// widths of the fixed-point data path.
	localparam int ActW = 8;
	localparam int WeightW = 8;
	localparam int BiasW = 16;
	localparam int AccW = 23;

	// outputs keep the integer part of a value scaled by 64.
	localparam int FracBits = 6;
	localparam int ActMax = 127;

	typedef logic signed [ActW-1:0] actT;
	typedef logic signed [WeightW-1:0] weightT;

	// bias carries the same scale as the products.
	typedef logic signed [BiasW-1:0] biasT;

	// wide enough for NumInputs full-scale products plus the bias.
	typedef logic signed [AccW-1:0] accT;

	typedef enum logic [1:0]
	{
		Fill,
		WaitAckLow,
		Hold
	} collectStateT;

	typedef enum logic [1:0]
	{
		Idle,
		Compute,
		Offer,
		Release
	} argStateT;

endpackage

// File: rtl/nnWeightsPkg.sv
package nnWeightsPkg;

	import nnTypesPkg::*;

	localparam int DefNumInputs = 15;
	localparam int DefNumNeurons = 4;

	// rows and elements are listed from the highest index down, so row 0 comes last.
	localparam weightT [DefNumNeurons-1:0][DefNumInputs-1:0] DefWeights =
	'{
		'{
			14, -16, 5, -28, 26,
			-18, 11, -4, 31, 9,
			-24, 15, -7, -13, 22
		},
		'{
			29, 8, -20, 17, -2,
			24, -30, 6, -15, 28,
			13, -26, 4, 19, -9
		},
		'{
			-11, 21, -6, 10, -27,
			3, 18, -22, 7, -5,
			30, -14, 25, -8, 12
		},
		// row 0 carries the weights of the single-neuron classifier.
		'{
			-3, 31, 4, -31, 9,
			-29, -25, 31, 16, 27,
			0, 31, -23, 0, -17
		}
	};

	// neurons 0 and 1 both round to 8 on a zero frame.
	localparam biasT [DefNumNeurons-1:0] DefBiases =
	'{
		448,
		-256,
		500,
		512
	};

endpackage

// File: rtl/nnInputCollector.sv
`timescale 1ns/1ps

module nnInputCollector #(
	parameter int NumInputs = 15
) (
	input logic clk,
	input logic reset,
	input nnTypesPkg::actT inData,
	input logic inReq,
	output logic inAck,
	input logic argReady,
	output nnTypesPkg::actT [NumInputs-1:0] frameData,
	output logic frameValid
);

	import nnTypesPkg::*;

	// count reaches NumInputs once the frame is full.
	localparam int CountW = $clog2(NumInputs + 1);

	collectStateT state;
	logic [CountW-1:0] count;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= Fill;
			count <= '0;
			inAck <= 1'b0;
		end
		else
		begin
			case (state)
				Fill:
				begin
					if (inReq)
					begin
						inAck <= 1'b1;
						count <= count + 1'b1;
						state <= WaitAckLow;
					end
				end
				WaitAckLow:
				begin
					// the frame is only complete once the last ack is released.
					if (!inReq)
					begin
						inAck <= 1'b0;
						state <= (count == CountW'(NumInputs)) ? Hold : Fill;
					end
				end
				Hold:
				begin
					if (argReady)
					begin
						count <= '0;
						state <= Fill;
					end
				end
				default:
				begin
					state <= Fill;
				end
			endcase
		end
	end

	// first activation received lands in index 0.
	always_ff @(posedge clk)
	begin
		if (state == Fill && inReq)
		begin
			frameData[count] <= inData;
		end
	end

	// no new request is taken while in Hold, so the source stalls.
	assign frameValid = (state == Hold) && argReady;

endmodule

// File: rtl/nnNeuron.sv
`timescale 1ns/1ps

module nnNeuron #(
	parameter int NumInputs = 15,
	parameter nnTypesPkg::weightT [NumInputs-1:0] Weights = '0,
	parameter nnTypesPkg::biasT Bias = '0
) (
	input logic clk,
	input logic reset,
	input nnTypesPkg::actT [NumInputs-1:0] inAct,
	input logic inValid,
	output nnTypesPkg::actT outAct,
	output logic outValid
);

	import nnTypesPkg::*;

	actT actReg [NumInputs];
	logic stageValid;
	accT sum;
	accT rounded;

	// stage 1.
	always_ff @(posedge clk)
	begin
		if (inValid)
		begin
			for (int i = 0; i < NumInputs; i++)
			begin
				actReg[i] <= inAct[i];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			stageValid <= 1'b0;
			outValid <= 1'b0;
		end
		else
		begin
			stageValid <= inValid;
			outValid <= stageValid;
		end
	end

	always_comb
	begin
		sum = accT'(Bias);
		for (int i = 0; i < NumInputs; i++)
		begin
			sum = sum + accT'(actReg[i]) * accT'(signed'(Weights[i]));
		end
		// round half up with the bit just below the kept part.
		rounded = (sum >>> FracBits) + accT'(sum[FracBits-1]);
	end

	// stage 2.
	always_ff @(posedge clk)
	begin
		if (stageValid)
		begin
			if (rounded < 0)
			begin
				outAct <= '0;
			end
			else if (rounded > accT'(ActMax))
			begin
				// saturating after the round keeps 127 from wrapping.
				outAct <= actT'(ActMax);
			end
			else
			begin
				outAct <= actT'(rounded);
			end
		end
	end

endmodule

// File: rtl/nnLayer.sv
`timescale 1ns/1ps

module nnLayer #(
	parameter int NumInputs = 15,
	parameter int NumNeurons = 4,
	parameter nnTypesPkg::weightT [NumNeurons-1:0][NumInputs-1:0] Weights = '0,
	parameter nnTypesPkg::biasT [NumNeurons-1:0] Biases = '0
) (
	input logic clk,
	input logic reset,
	input nnTypesPkg::actT [NumInputs-1:0] frameData,
	input logic frameValid,
	output nnTypesPkg::actT [NumNeurons-1:0] layerOut,
	output logic layerValid
);

	genvar n;

	generate
		for (n = 0; n < NumNeurons; n++)
		begin : gNeuron
			// every neuron has the same latency, so one valid bit is enough.
			if (n == 0)
			begin : gFirst
				nnNeuron #(
					.NumInputs(NumInputs),
					.Weights(Weights[n]),
					.Bias(Biases[n])
				) uNeuron (
					.clk(clk),
					.reset(reset),
					.inAct(frameData),
					.inValid(frameValid),
					.outAct(layerOut[n]),
					.outValid(layerValid)
				);
			end
			else
			begin : gOther
				nnNeuron #(
					.NumInputs(NumInputs),
					.Weights(Weights[n]),
					.Bias(Biases[n])
				) uNeuron (
					.clk(clk),
					.reset(reset),
					.inAct(frameData),
					.inValid(frameValid),
					.outAct(layerOut[n]),
					.outValid()
				);
			end
		end
	endgenerate

endmodule

// File: rtl/nnArgmax.sv
`timescale 1ns/1ps

module nnArgmax #(
	parameter int NumNeurons = 4
) (
	input logic clk,
	input logic reset,
	input logic frameValid,
	input nnTypesPkg::actT [NumNeurons-1:0] layerOut,
	input logic layerValid,
	output logic argReady,
	output logic [$clog2(NumNeurons)-1:0] resClass,
	output nnTypesPkg::actT resScore,
	output logic resReq,
	input logic resAck
);

	import nnTypesPkg::*;

	localparam int ClassW = $clog2(NumNeurons);

	argStateT state;
	logic [ClassW-1:0] bestIdx;
	actT bestVal;

	// a strict compare lets the lower index win a tie.
	always_comb
	begin
		bestIdx = '0;
		bestVal = layerOut[0];
		for (int i = 1; i < NumNeurons; i++)
		begin
			if (layerOut[i] > bestVal)
			begin
				bestIdx = ClassW'(i);
				bestVal = layerOut[i];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= Idle;
		end
		else
		begin
			case (state)
				Idle:
				begin
					// the frame is claimed while it is still in the neurons.
					if (frameValid)
					begin
						state <= Compute;
					end
				end
				Compute:
				begin
					if (layerValid)
					begin
						state <= Offer;
					end
				end
				Offer:
				begin
					if (resAck)
					begin
						state <= Release;
					end
				end
				Release:
				begin
					if (!resAck)
					begin
						state <= Idle;
					end
				end
				default:
				begin
					state <= Idle;
				end
			endcase
		end
	end

	// held until the next frame reaches the layer output.
	always_ff @(posedge clk)
	begin
		if (state == Compute && layerValid)
		begin
			resClass <= bestIdx;
			resScore <= bestVal;
		end
	end

	assign argReady = (state == Idle);
	assign resReq = (state == Offer);

endmodule

// File: rtl/nnClassifierTop.sv
`timescale 1ns/1ps

module nnClassifierTop #(
	parameter int NumInputs = nnWeightsPkg::DefNumInputs,
	parameter int NumNeurons = nnWeightsPkg::DefNumNeurons,
	parameter nnTypesPkg::weightT [NumNeurons-1:0][NumInputs-1:0] Weights =
		nnWeightsPkg::DefWeights,
	parameter nnTypesPkg::biasT [NumNeurons-1:0] Biases = nnWeightsPkg::DefBiases
) (
	input logic clk,
	input logic reset,
	input nnTypesPkg::actT inData,
	input logic inReq,
	output logic inAck,
	output logic [$clog2(NumNeurons)-1:0] resClass,
	output nnTypesPkg::actT resScore,
	output logic resReq,
	input logic resAck
);

	import nnTypesPkg::*;

	actT [NumInputs-1:0] frameData;
	logic frameValid;
	logic argReady;
	actT [NumNeurons-1:0] layerOut;
	logic layerValid;

	nnInputCollector #(
		.NumInputs(NumInputs)
	) uCollector (
		.clk(clk),
		.reset(reset),
		.inData(inData),
		.inReq(inReq),
		.inAck(inAck),
		.argReady(argReady),
		.frameData(frameData),
		.frameValid(frameValid)
	);

	nnLayer #(
		.NumInputs(NumInputs),
		.NumNeurons(NumNeurons),
		.Weights(Weights),
		.Biases(Biases)
	) uLayer (
		.clk(clk),
		.reset(reset),
		.frameData(frameData),
		.frameValid(frameValid),
		.layerOut(layerOut),
		.layerValid(layerValid)
	);

	nnArgmax #(
		.NumNeurons(NumNeurons)
	) uArgmax (
		.clk(clk),
		.reset(reset),
		.frameValid(frameValid),
		.layerOut(layerOut),
		.layerValid(layerValid),
		.argReady(argReady),
		.resClass(resClass),
		.resScore(resScore),
		.resReq(resReq),
		.resAck(resAck)
	);

endmodule

// File: tb/nnHandshake_sva.sv
`timescale 1ns/1ps

module nnHandshake_sva #(
	parameter int NumNeurons = 4
) (
	input logic clk,
	input logic reset,
	input logic inReq,
	input logic inAck,
	input logic frameValid,
	input logic [$clog2(NumNeurons)-1:0] resClass,
	input nnTypesPkg::actT resScore,
	input logic resReq,
	input logic resAck
);

	// an ack only answers a request seen on the edge before.
	inAckNeedsReq: assert property (@(posedge clk) disable iff (reset)
		$rose(inAck) |-> $past(inReq))
		else $error("inAck rose without a pending inReq");

	resultStable: assert property (@(posedge clk) disable iff (reset)
		resReq && $past(resReq) |-> $stable(resClass) && $stable(resScore))
		else $error("result changed while resReq was high");

	reqHeldUntilAck: assert property (@(posedge clk) disable iff (reset)
		resReq && !resAck |=> resReq)
		else $error("resReq dropped before resAck");

	// frameValid, two neuron stages, then the argmax latch.
	frameToResult: assert property (@(posedge clk) disable iff (reset)
		$past(frameValid, 3) && !$past(resAck, 3) && !$past(reset, 1) &&
		!$past(reset, 2) && !$past(reset, 3) |-> $rose(resReq))
		else $error("resReq did not rise 3 cycles after frameValid");

endmodule

bind nnClassifierTop nnHandshake_sva #(
	.NumNeurons(NumNeurons)
) uHandshakeSva (
	.clk(clk),
	.reset(reset),
	.inReq(inReq),
	.inAck(inAck),
	.frameValid(frameValid),
	.resClass(resClass),
	.resScore(resScore),
	.resReq(resReq),
	.resAck(resAck)
);

// File: tb/nnClassifierTb.sv
`timescale 1ns/1ps

module nnClassifierTb;

	import nnTypesPkg::*;
	import nnWeightsPkg::*;

	localparam int NumIn = DefNumInputs;
	localparam int NumNeu = DefNumNeurons;
	localparam int ClassW = $clog2(NumNeu);
	// frames sent over all tests including the partial one.
	localparam int NumFrames = 54;
	localparam int WatchCycles = NumFrames * (NumIn * 6 + 40);

	typedef actT [NumIn-1:0] frameT;

	logic clk;
	logic reset;
	actT inData;
	logic inReq;
	logic inAck;
	logic [ClassW-1:0] resClass;
	actT resScore;
	logic resReq;
	logic resAck;

	int expClassQ[$];
	int expScoreQ[$];
	int gotClassQ[$];
	int gotScoreQ[$];
	int pushed;
	int compared;
	int checks;
	int errors;
	int tests;
	int errorsAtStart;
	int ackDelay;
	integer seed;
	string curTest;

	nnClassifierTop uut (
		.clk(clk),
		.reset(reset),
		.inData(inData),
		.inReq(inReq),
		.inAck(inAck),
		.resClass(resClass),
		.resScore(resScore),
		.resReq(resReq),
		.resAck(resAck)
	);

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#10 clk = ~clk;
		end
	end

	// each neuron output is rounded and clipped, and the lowest index among maxima wins.
	function automatic void expectClass(input frameT frame, output int cls, output int score);
		int acc;
		int val;
		cls = 0;
		score = -1;
		for (int n = 0; n < NumNeu; n++)
		begin
			acc = int'(signed'(DefBiases[n]));
			for (int i = 0; i < NumIn; i++)
			begin
				acc = acc + int'(signed'(frame[i])) * int'(signed'(DefWeights[n][i]));
			end
			val = (acc + 32) >>> 6;
			val = (val < 0) ? 0 : ((val > 127) ? 127 : val);
			if (val > score)
			begin
				cls = n;
				score = val;
			end
		end
	endfunction

	function automatic frameT randomFrame(input bit narrow);
		frameT frame;
		for (int i = 0; i < NumIn; i++)
		begin
			frame[i] = narrow ? actT'($random(seed) % 40) : actT'($random(seed));
		end
		return frame;
	endfunction

	task automatic stepClk();
		@(posedge clk);
		#2;
	endtask

	task automatic checkValue(input string name, input string field, input int expected,
		input int actual);
		checks++;
		if (expected != actual)
		begin
			errors++;
			$display("CHECK FAILED %s %s: expected %0d, actual %0d", name, field, expected,
				actual);
		end
	endtask

	task automatic expectResult(input int cls, input int score);
		expClassQ.push_back(cls);
		expScoreQ.push_back(score);
		pushed++;
	endtask

	task automatic queueModel(input frameT frame);
		int cls;
		int score;
		expectClass(frame, cls, score);
		expectResult(cls, score);
	endtask

	// the four-phase source sends one activation per handshake.
	task automatic sendFrame(input frameT frame, input int count);
		for (int i = 0; i < count; i++)
		begin
			inData = frame[i];
			inReq = 1'b1;
			stepClk();
			while (!inAck)
			begin
				stepClk();
			end
			inReq = 1'b0;
			stepClk();
			while (inAck)
			begin
				stepClk();
			end
		end
	endtask

	task automatic applyReset();
		reset = 1'b1;
		repeat (2) stepClk();
		reset = 1'b0;
		stepClk();
	endtask

	task automatic startTest(input string name);
		curTest = name;
		errorsAtStart = errors;
	endtask

	// a few idle cycles after the last result catch anything offered late.
	task automatic finishTest();
		while (compared < pushed)
		begin
			stepClk();
		end
		repeat (10) stepClk();
		tests++;
		if (errors == errorsAtStart)
		begin
			$display("test %0d %s: ok", tests, curTest);
		end
		else
		begin
			$display("test %0d %s: %0d errors", tests, curTest, errors - errorsAtStart);
		end
	endtask

	// the sink waits a settable number of cycles before each ack.
	initial
	begin
		forever
		begin
			stepClk();
			if (resReq && !reset)
			begin
				gotClassQ.push_back(int'(resClass));
				gotScoreQ.push_back(int'(resScore));
				repeat (ackDelay) stepClk();
				resAck = 1'b1;
				while (resReq)
				begin
					stepClk();
				end
				resAck = 1'b0;
			end
		end
	end

	initial
	begin
		int gc;
		int gs;
		forever
		begin
			@(negedge clk);
			while (gotClassQ.size() > 0)
			begin
				gc = gotClassQ.pop_front();
				gs = gotScoreQ.pop_front();
				if (expClassQ.size() == 0)
				begin
					errors++;
					$display("%s: result class %0d score %0d offered with no frame pending",
						curTest, gc, gs);
				end
				else
				begin
					checkValue(curTest, "class", expClassQ.pop_front(), gc);
					checkValue(curTest, "score", expScoreQ.pop_front(), gs);
					compared++;
				end
			end
		end
	end

	initial
	begin
		repeat (WatchCycles) @(posedge clk);
		$display("timeout: tests did not finish within %0d cycles", WatchCycles);
		$display("CHECKS FAILED");
		$finish;
	end

	initial
	begin
		frameT frame;
		reset = 1'b1;
		inData = '0;
		inReq = 1'b0;
		resAck = 1'b0;
		ackDelay = 0;
		seed = 50;
		pushed = 0;
		compared = 0;
		checks = 0;
		errors = 0;
		tests = 0;
		curTest = "reset";
		repeat (2) stepClk();
		reset = 1'b0;
		stepClk();

		startTest("reference vector");
		frame = '0;
		frame[7] = actT'(10);
		frame[11] = actT'(-5);
		frame[13] = actT'(10);
		// 512 + 155 + 310 + 310 = 1287 rounds to 20.
		expectResult(0, 20);
		sendFrame(frame, NumIn);
		finishTest();

		startTest("relu and saturation");
		frame = '0;
		frame[6] = actT'(-60);
		frame[10] = actT'(60);
		frame[11] = actT'(60);
		frame[12] = actT'(120);
		expectResult(0, 0);
		sendFrame(frame, NumIn);
		for (int i = 0; i < NumIn; i++)
		begin
			frame[i] = (signed'(DefWeights[0][i]) > 0) ? actT'(127) :
				((signed'(DefWeights[0][i]) < 0) ? actT'(-127) : actT'(0));
		end
		expectResult(0, 127);
		sendFrame(frame, NumIn);
		// acc of 8170 rounds up to 128 before the clip.
		frame = '0;
		frame[6] = actT'(2);
		frame[7] = actT'(127);
		frame[13] = actT'(119);
		expectResult(0, 127);
		sendFrame(frame, NumIn);
		finishTest();

		startTest("argmax ties");
		frame = '0;
		expectResult(0, 8);
		sendFrame(frame, NumIn);
		// neurons 1 and 3 both give 9.
		frame[0] = actT'(5);
		expectResult(1, 9);
		sendFrame(frame, NumIn);
		finishTest();

		startTest("random frames");
		for (int f = 0; f < 40; f++)
		begin
			frame = randomFrame(f[0] == 1'b0);
			queueModel(frame);
			sendFrame(frame, NumIn);
		end
		finishTest();

		startTest("back-pressure");
		ackDelay = 30;
		for (int f = 0; f < 6; f++)
		begin
			frame = randomFrame(1'b1);
			queueModel(frame);
			sendFrame(frame, NumIn);
		end
		finishTest();
		ackDelay = 0;

		startTest("reset mid-frame");
		frame = randomFrame(1'b1);
		sendFrame(frame, 7);
		applyReset();
		frame = randomFrame(1'b1);
		queueModel(frame);
		sendFrame(frame, NumIn);
		finishTest();

		$display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
		begin
			$display("ALL CHECKS PASSED");
		end
		else
		begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// File: Makefile
VERILATOR ?= verilator
TOP := nnClassifierTb
FILELIST := project.f
BUILD_FLAGS := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing -Wall
PASS_MSG := ALL CHECKS PASSED
SIM := obj_dir/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "^$(PASS_MSG)$$"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

// File: project.f
rtl/nnTypesPkg.sv
rtl/nnWeightsPkg.sv
rtl/nnInputCollector.sv
rtl/nnNeuron.sv
rtl/nnLayer.sv
rtl/nnArgmax.sv
rtl/nnClassifierTop.sv
tb/nnHandshake_sva.sv
tb/nnClassifierTb.sv
